// ==== sim.f ====
src/z80_io_pkg.sv
src/z80_io_decode.sv
src/sync_stretch.sv
src/z80_wr_cdc.sv
src/io_port_bank.sv
src/z80_io_top.sv
tb/z80_io_sva.sv
tb/z80_io_tb.sv

// ==== Makefile ====
TOP = z80_io_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// ==== tb/z80_io_tb.sv ====
`timescale 1ns/1ps

module z80_io_tb
    import z80_io_pkg::*;
();

    logic               wr_tick1;
    logic               cpu_phi;
    logic               reset;
    z80_bus_t           z80_bus;
    port_bank_t         port_out;
    logic [COUNT_W-1:0] wr_count;

    // reference state of the four ports and the accepted write count
    logic [7:0]         model_port [0:IO_PORTS-1];
    logic [COUNT_W-1:0] model_count;

    integer seed;
    int     errors;
    int     tests;
    int     failed_tests;
    int     test_start;
    string  test_name;

    z80_io_top UUT (
        .wr_tick1(wr_tick1),
        .cpu_phi(cpu_phi),
        .reset(reset),
        .z80_bus(z80_bus),
        .port_out(port_out),
        .wr_count(wr_count)
    );

    // peripheral clock at 20 ns and a slower unrelated CPU clock at 56 ns
    always #10 wr_tick1 = ~wr_tick1;
    always #28 cpu_phi = ~cpu_phi;

    // ****************************************
    // reference model and checks
    // ****************************************

    // value checks plus every failure seen by the bound assertions
    function automatic int total_failures();
        return errors + UUT.u_cdc.sva_cdc.fail_count + UUT.u_bank.sva_bank.fail_count;
    endfunction

    // a write lands in the port picked by the low two address bits, and the count wraps
    function automatic void model_write(input logic [7:0] addr, input logic [7:0] data);
        model_port[addr[1:0]] = data;
        model_count = model_count + 1'b1;
    endfunction

    // compares both outputs with the model away from any wr_tick1 edge
    task automatic check_state();
        port_bank_t exp_bank;
        exp_bank.port0 = model_port[0];
        exp_bank.port1 = model_port[1];
        exp_bank.port2 = model_port[2];
        exp_bank.port3 = model_port[3];
        @(negedge wr_tick1);
        assert (port_out === exp_bank) else begin
            $display("mismatch %s port_out: expected %h actual %h", test_name, exp_bank, port_out);
            errors++;
        end
        assert (wr_count === model_count) else begin
            $display("mismatch %s wr_count: expected %h actual %h",
                     test_name, model_count, wr_count);
            errors++;
        end
    endtask

    // polls the counter until it reaches the target or the limit runs out
    task automatic wait_count(input logic [COUNT_W-1:0] target, input int limit);
        int cycles;
        cycles = 0;
        while (wr_count !== target && cycles < limit) begin
            @(negedge wr_tick1);
            cycles++;
        end
        if (wr_count !== target) begin
            $display("test %s: write counter never reached %0d within %0d wr_tick1 cycles",
                     test_name, target, limit);
            errors++;
        end
    endtask

    // ****************************************
    // bus stimulus
    // ****************************************

    // one I/O write with address and data set up a cycle before iorq and wr fall
    task automatic bus_write(input logic [7:0] addr, input logic [7:0] data,
                             input logic m1_n, input int hold);
        @(posedge cpu_phi);
        #2;
        z80_bus.addr = addr;
        z80_bus.data = data;
        z80_bus.m1_n = m1_n;
        @(posedge cpu_phi);
        #2;
        z80_bus.iorq_n = 1'b0;
        z80_bus.wr_n   = 1'b0;
        repeat (hold) @(posedge cpu_phi);
        #2;
        z80_bus.iorq_n = 1'b1;
        z80_bus.wr_n   = 1'b1;
        z80_bus.m1_n   = 1'b1;
        // the address phase of the next call gives the second idle sample
        @(posedge cpu_phi);
    endtask

    task automatic write_and_check(input logic [7:0] addr, input logic [7:0] data, input int hold);
        bus_write(addr, data, 1'b1, hold);
        model_write(addr, data);
        wait_count(model_count, 100);
        check_state();
    endtask

    // a cycle the decoder must drop has no count change to wait for
    task automatic write_ignored(input logic [7:0] addr, input logic [7:0] data,
                                 input logic m1_n);
        bus_write(addr, data, m1_n, 3);
        repeat (40) @(negedge wr_tick1);
        check_state();
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_start = total_failures();
        tests++;
    endtask

    task automatic end_test();
        if (total_failures() == test_start) begin
            $display("test %s: ok", test_name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", test_name, total_failures() - test_start);
        end
    endtask

    // ****************************************
    // test sequence
    // ****************************************

    initial begin
        logic [7:0] data;
        seed         = 32'h4c0d_dccb;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        wr_tick1     = 1'b0;
        cpu_phi      = 1'b0;
        reset        = 1'b1;
        z80_bus      = '{iorq_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1, addr: 8'h00, data: 8'h00};
        for (int i = 0; i < IO_PORTS; i++) begin
            model_port[i] = 8'h00;
        end
        model_count = '0;

        // eight wr_tick1 cycles also span several cpu_phi edges
        repeat (8) @(posedge wr_tick1);
        #2;
        reset = 1'b0;

        start_test("reset_state");
        repeat (2) @(negedge wr_tick1);
        check_state();
        end_test();

        start_test("port_write");
        for (int i = 0; i < IO_PORTS; i++) begin
            data = 8'($random(seed));
            write_and_check(IO_BASE + 8'(i), data, 3);
        end
        end_test();

        // just below, just above, far outside the window, then an acknowledge cycle
        start_test("outside_window");
        write_ignored(IO_BASE - 8'd1, 8'($random(seed)), 1'b1);
        write_ignored(IO_BASE + 8'd4, 8'($random(seed)), 1'b1);
        write_ignored(8'hc1, 8'($random(seed)), 1'b1);
        write_ignored(IO_BASE + 8'd1, 8'($random(seed)), 1'b0);
        end_test();

        start_test("long_cycle");
        data = 8'($random(seed));
        write_and_check(IO_BASE + 8'd2, data, 6);
        // a second tick from the same cycle would have arrived by now
        repeat (40) @(negedge wr_tick1);
        check_state();
        end_test();

        // 300 writes four cpu_phi cycles apart carry the counter past its wrap
        start_test("burst_wrap");
        for (int i = 0; i < 300; i++) begin
            data = 8'($random(seed));
            bus_write(IO_BASE + 8'd1, data, 1'b1, 1);
            model_write(IO_BASE + 8'd1, data);
        end
        wait_count(model_count, 200);
        check_state();
        end_test();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests, failed_tests, total_failures());
        if (failed_tests == 0 && total_failures() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== tb/z80_io_sva.sv ====
`timescale 1ns/1ps

module z80_io_sva
    import z80_io_pkg::*;
#(
    // set for the instance in the crossing and clear for the one in the port bank
    parameter bit CDC_SIDE = 1'b1
) (
    input logic               cpu_phi,
    input logic               wr_tick1,
    input logic               reset,
    input logic               io_tick,
    input logic               wr_stb,
    input io_wr_t             wr_dst,
    input logic [COUNT_W-1:0] wr_count
);

    // number of assertion failures, summed into the test results
    int fail_count = 0;

    // the crossing sees the tick, the strobe and the payload
    // so the checks on those live there and the port bank keeps only the counter
    if (CDC_SIDE) begin : g_cdc

        // ****************************************
        // cpu_phi domain
        // ****************************************

        // one bus cycle gives exactly one tick
        tick_width: assert property (@(posedge cpu_phi) disable iff (reset) io_tick |=> !io_tick)
        else begin
            $error("io_tick stayed high for more than one cpu_phi cycle");
            fail_count++;
        end

        // ****************************************
        // wr_tick1 domain
        // ****************************************

        // the edge detect after the synchronizer allows only single cycle strobes
        stb_width: assert property (@(posedge wr_tick1) disable iff (reset) wr_stb |=> !wr_stb)
        else begin
            $error("wr_stb stayed high for two wr_tick1 cycles");
            fail_count++;
        end

        // the payload was loaded long before the strobe crossed, so it must not move now
        dst_stable: assert property (@(posedge wr_tick1) disable iff (reset)
                                     wr_stb |-> $stable(wr_dst))
        else begin
            $error("wr_dst changed while wr_stb was high");
            fail_count++;
        end

        // synchronous reset clears the strobe on the next edge
        stb_reset: assert property (@(posedge wr_tick1) reset |=> !wr_stb)
        else begin
            $error("wr_stb not zero during reset");
            fail_count++;
        end

    end else begin : g_bank

        // synchronous reset clears the write counter on the next edge
        count_reset: assert property (@(posedge wr_tick1) reset |=> wr_count == '0)
        else begin
            $error("wr_count not zero during reset");
            fail_count++;
        end

    end

endmodule

// the crossing has no counter of its own and its counter input is not checked there
bind z80_wr_cdc z80_io_sva #(.CDC_SIDE(1'b1)) sva_cdc (
    .cpu_phi(cpu_phi),
    .wr_tick1(wr_tick1),
    .reset(reset),
    .io_tick(io_tick),
    .wr_stb(wr_stb),
    .wr_dst(wr_dst),
    .wr_count('0)
);

// the port bank lives only in wr_tick1 and its checks cover the counter alone
bind io_port_bank z80_io_sva #(.CDC_SIDE(1'b0)) sva_bank (
    .cpu_phi(wr_tick1),
    .wr_tick1(wr_tick1),
    .reset(reset),
    .io_tick(1'b0),
    .wr_stb(wr_stb),
    .wr_dst(wr_dst),
    .wr_count(wr_count)
);

// ==== src/z80_io_top.sv ====
`timescale 1ns/1ps

// ****************************************
// Z80 I/O write bridge top level
// ****************************************

module z80_io_top
    import z80_io_pkg::*;
(
    input  logic               wr_tick1,
    input  logic               cpu_phi,
    input  logic               reset,
    input  z80_bus_t           z80_bus,
    output port_bank_t         port_out,
    output logic [COUNT_W-1:0] wr_count
);

    // one cycle tick in cpu_phi for each write to the port window
    logic   io_tick;
    // the payload captured by the decoder along with the tick
    io_wr_t wr_src;
    // one cycle strobe in wr_tick1 after the crossing
    logic   wr_stb;
    // the held payload as seen by the peripheral domain
    io_wr_t wr_dst;

    // bus watcher in the CPU domain
    z80_io_decode u_decode (
        .cpu_phi(cpu_phi),
        .reset(reset),
        .z80_bus(z80_bus),
        .io_tick(io_tick),
        .wr_src(wr_src)
    );

    // moves the tick and its payload into the wr_tick1 domain
    z80_wr_cdc u_cdc (
        .reset(reset),
        .cpu_phi(cpu_phi),
        .wr_tick1(wr_tick1),
        .io_tick(io_tick),
        .wr_src(wr_src),
        .wr_stb(wr_stb),
        .wr_dst(wr_dst)
    );

    // the port registers and write counter live entirely in wr_tick1
    io_port_bank u_bank (
        .wr_tick1(wr_tick1),
        .reset(reset),
        .wr_stb(wr_stb),
        .wr_dst(wr_dst),
        .port_out(port_out),
        .wr_count(wr_count)
    );

endmodule

// ==== src/io_port_bank.sv ====
`timescale 1ns/1ps

// ****************************************
// output port registers and write counter
// ****************************************

module io_port_bank
    import z80_io_pkg::*;
(
    input  logic               wr_tick1,
    input  logic               reset,
    input  logic               wr_stb,
    input  io_wr_t             wr_dst,
    output port_bank_t         port_out,
    output logic [COUNT_W-1:0] wr_count
);

    // the window is aligned so the low address bits pick the port directly
    logic [1:0] sel;

    assign sel = wr_dst.addr[1:0];

    // ****************************************
    // port registers
    // ****************************************

    // each strobe writes exactly one port and the others keep their value
    // the decoder already filtered the address so every strobe is a hit
    always_ff @(posedge wr_tick1) begin
        if (reset) begin
            port_out <= '0;
        end else if (wr_stb) begin
            case (sel)
                2'd0: begin
                    port_out.port0 <= wr_dst.data;
                end
                2'd1: begin
                    port_out.port1 <= wr_dst.data;
                end
                2'd2: begin
                    port_out.port2 <= wr_dst.data;
                end
                default: begin
                    port_out.port3 <= wr_dst.data;
                end
            endcase
        end
    end

    // ****************************************
    // write counter
    // ****************************************

    // counts every accepted write and wraps at COUNT_W bits
    // it changes on the same edge as the port so a change in the count
    // tells the outside that the new port value is in place
    always_ff @(posedge wr_tick1) begin
        if (reset) begin
            wr_count <= '0;
        end else if (wr_stb) begin
            wr_count <= wr_count + 1'b1;
        end
    end

endmodule

// ==== src/z80_wr_cdc.sv ====
`timescale 1ns/1ps

// ****************************************
// write payload crossing from cpu_phi to wr_tick1
// ****************************************

module z80_wr_cdc
    import z80_io_pkg::*;
(
    input  logic   reset,
    input  logic   cpu_phi,
    input  logic   wr_tick1,
    input  logic   io_tick,
    input  io_wr_t wr_src,
    output logic   wr_stb,
    output io_wr_t wr_dst
);

    // payload held in the source domain from one tick to the next
    io_wr_t held;

    // the payload register loads on the same edge that starts the stretch
    // by the time the strobe reaches wr_tick1 it has been stable for
    // several destination cycles so it meets setup and hold there
    always_ff @(posedge cpu_phi) begin
        if (io_tick) begin
            held <= wr_src;
        end
    end

    // ****************************************
    // strobe crossing
    // ****************************************

    // the tick is stretched over STRETCH_LEN cpu_phi cycles so the slower
    // source pulse is always seen by the faster destination clock
    sync_stretch #(
        .STRETCH_BITS(STRETCH_LEN),
        .SYNC_LEN(SYNC_LEN)
    ) u_sync_stretch (
        .reset(reset),
        .clk1(cpu_phi),
        .clk2(wr_tick1),
        .in(io_tick),
        .out(wr_stb)
    );

    // the held value is presented unchanged alongside the crossed strobe
    // and the CPU spacing keeps it stable until the strobe has been used
    assign wr_dst = held;

endmodule

// ==== src/sync_stretch.sv ====
`timescale 1ns/1ps

// ****************************************
// pulse stretcher and synchronizer
// ****************************************

module sync_stretch
    import z80_io_pkg::*;
#(
    // clk1 cycles that the stretched level stays high after an input pulse
    parameter int STRETCH_BITS = STRETCH_LEN,
    // flops in the clk2 synchronizer chain which must be at least two
    parameter int SYNC_LEN = z80_io_pkg::SYNC_LEN
) (
    input  logic reset,
    input  logic clk1,
    input  logic clk2,
    input  logic in,
    output logic out
);

    // wide enough to hold STRETCH_BITS-1 even when STRETCH_BITS is one
    localparam int CNT_W = $clog2(STRETCH_BITS + 1);

    // cycles left after the current one in which the level stays high
    logic [CNT_W-1:0] cnt;
    // the stretched level that crosses into clk2
    logic level;

    // synchronizer chain in clk2 where bit 0 is the first flop
    logic [SYNC_LEN-1:0] sync_q;
    // the synchronized level one clk2 cycle later for edge detection
    logic seen_q;

    // ****************************************
    // clk1 side stretcher
    // ****************************************

    // every input pulse restarts the count so a pulse during a running
    // stretch only extends the level
    // the level comes straight from a flop so it cannot glitch across the boundary
    always_ff @(posedge clk1) begin
        if (reset) begin
            cnt   <= '0;
            level <= 1'b0;
        end else if (in) begin
            cnt   <= CNT_W'(STRETCH_BITS - 1);
            level <= 1'b1;
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            level <= 1'b0;
        end
    end

    // ****************************************
    // clk2 side synchronizer and edge detect
    // ****************************************

    // the first flop may go metastable and the rest of the chain gives it time to settle
    // out is registered so the pulse is exactly one clk2 cycle wide
    always_ff @(posedge clk2) begin
        if (reset) begin
            sync_q <= '0;
            seen_q <= 1'b0;
            out    <= 1'b0;
        end else begin
            sync_q <= {sync_q[SYNC_LEN-2:0], level};
            seen_q <= sync_q[SYNC_LEN-1];
            out    <= sync_q[SYNC_LEN-1] && !seen_q;
        end
    end

endmodule

// ==== src/z80_io_decode.sv ====
`timescale 1ns/1ps

// ****************************************
// I/O write cycle decoder in the cpu_phi domain
// ****************************************

module z80_io_decode
    import z80_io_pkg::*;
(
    input  logic     cpu_phi,
    input  logic     reset,
    input  z80_bus_t z80_bus,
    output logic     io_tick,
    output io_wr_t   wr_src
);

    // the low address bits that select a port inside the window
    localparam int SEL_W = $clog2(IO_PORTS);

    // registered copy of the bus pins so all decode works from one clean sample
    z80_bus_t bus_q;

    // high for every sample that belongs to a qualifying write cycle
    logic hit;
    // the value of hit one sample earlier
    logic hit_q;
    // the address falls inside the aligned port window
    logic in_window;

    // the window is aligned so only the upper address bits need to match
    assign in_window = (bus_q.addr[7:SEL_W] == IO_BASE[7:SEL_W]);

    // an I/O write has iorq and wr low together
    // m1 low with iorq low is an interrupt acknowledge and must not be taken as a write
    assign hit = !bus_q.iorq_n && !bus_q.wr_n && bus_q.m1_n && in_window;

    // the bus sample register carries only payload and strobes from the pins
    always_ff @(posedge cpu_phi) begin
        bus_q <= z80_bus;
    end

    // ****************************************
    // edge detect on the qualified cycle
    // ****************************************

    // a cycle held for several samples keeps hit high the whole time
    // so only the first sample of the cycle produces a tick
    always_ff @(posedge cpu_phi) begin
        if (reset) begin
            hit_q   <= 1'b0;
            io_tick <= 1'b0;
        end else begin
            hit_q   <= hit;
            io_tick <= hit && !hit_q;
        end
    end

    // the payload is loaded only on the first sample so it is valid
    // while io_tick is high and keeps that value until the next cycle
    always_ff @(posedge cpu_phi) begin
        if (hit && !hit_q) begin
            wr_src.addr <= bus_q.addr;
            wr_src.data <= bus_q.data;
        end
    end

endmodule

// ==== src/z80_io_pkg.sv ====
// ****************************************
// shared types for the Z80 I/O write bridge
// ****************************************

package z80_io_pkg;

    // one sample of the CPU bus pins taken on a rising cpu_phi edge
    // the strobes keep their active low sense as they appear on the pins
    typedef struct packed {
        logic       iorq_n;
        logic       wr_n;
        logic       m1_n;
        logic [7:0] addr;
        logic [7:0] data;
    } z80_bus_t;

    // the write payload that crosses from the CPU domain into the peripheral domain
    typedef struct packed {
        logic [7:0] addr;
        logic [7:0] data;
    } io_wr_t;

    // the four output ports as one vector
    // port0 sits in the low byte so the vector reads like a little endian word
    typedef struct packed {
        logic [7:0] port3;
        logic [7:0] port2;
        logic [7:0] port1;
        logic [7:0] port0;
    } port_bank_t;

    // first port address of the decoded window
    localparam logic [7:0] IO_BASE = 8'h40;
    // number of ports in the window which must be a power of two and aligned to IO_BASE
    localparam int IO_PORTS = 4;
    // cpu_phi cycles that a write tick is held high before it is synchronized
    localparam int STRETCH_LEN = 2;
    // number of synchronizer flops in the peripheral domain
    localparam int SYNC_LEN = 2;
    // width of the accepted write counter
    localparam int COUNT_W = 8;

endpackage
